// File: src/sm_pkg.sv
/* Shared definitions for the state machine: opcodes, the two instruction
   views, static configuration and the controller to data path command */
package sm_pkg;

  localparam int PC_W   = 5;  // 32-word program store
  localparam int WORD_W = 32;

  typedef enum logic [2:0] {
    JMP       = 3'd0,
    WAIT      = 3'd1,  // Not executed
    IN        = 3'd2,
    OUT       = 3'd3,
    PUSH_PULL = 3'd4,
    MOV       = 3'd5,
    IRQ       = 3'd6,  // Not executed
    SET       = 3'd7
  } sm_op_e;

  typedef struct packed {
    sm_op_e     op;
    logic [4:0] delay;
    logic [2:0] arg_a;  // Destination, source or condition
    logic [4:0] arg_b;  // Address, data or bit count
  } sm_fields_t;

  typedef struct packed {
    sm_op_e     op;
    logic [4:0] delay;
    logic [2:0] dest;
    logic [1:0] mov_op;  // None, invert, bit-reverse
    logic [2:0] src;
  } sm_mov_t;

  typedef union packed {
    sm_fields_t fields;
    sm_mov_t    mov;
  } sm_instr_u;

  typedef struct packed {
    logic [4:0] wrap_target;
    logic [4:0] wrap_end;
    logic       in_shift_right;
    logic       out_shift_right;
    logic [4:0] set_base;
    logic [2:0] set_count;
    logic [4:0] out_base;
    logic [5:0] out_count;
    logic [4:0] in_base;
  } sm_config_t;

  typedef struct packed {
    logic [WORD_W-1:0] new_val;
    logic              set_x;
    logic              set_y;
    logic              dec_x;
    logic              dec_y;
    logic              set_isr;
    logic              shift_isr;
    logic              set_osr;
    logic              shift_osr;
    logic              clr_isr;
    logic              wr_set_pins;
    logic              wr_set_dirs;
    logic              wr_out_pins;
    logic [4:0]        shift_n;  // 0 stands for 32
  } sm_dp_cmd_t;

endpackage

// File: src/sm_tick_timer.sv
`timescale 1ns/1ps
/* Integer clock divider giving the execute tick, and the countdown that
   holds off execution for an instruction's delay field */
module sm_tick_timer #(
  parameter int DIV_W = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [DIV_W-1:0] div_int,
  input  logic             load,
  input  logic [4:0]       delay_val,
  output logic             tick,
  output logic             delaying
);

  logic [DIV_W-1:0] div_cnt;
  logic [4:0]       delay_cnt;
  logic             wrap;

  assign wrap     = (div_int <= 1) || (div_cnt >= div_int - 1'b1);  // 0 and 1 run every cycle
  assign delaying = (delay_cnt != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else begin
      div_cnt <= wrap ? '0 : div_cnt + 1'b1;
      tick    <= wrap;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      delay_cnt <= '0;
    end else if (tick) begin
      if (load) begin
        delay_cnt <= delay_val;
      end else if (delaying) begin
        delay_cnt <= delay_cnt - 1'b1;  // One tick burned per count
      end
    end
  end

endmodule

// File: src/sm_scratch.sv
`timescale 1ns/1ps
/* General purpose scratch register, instantiated once for X and once for Y.
   Load wins over decrement */
module sm_scratch (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      set,
  input  logic                      dec,
  input  logic [sm_pkg::WORD_W-1:0] din,
  output logic [sm_pkg::WORD_W-1:0] q
);

  always_ff @(posedge clk) begin
    if (reset) begin
      q <= '0;
    end else if (set) begin
      q <= din;
    end else if (dec) begin
      q <= q - 1'b1;  // JMP post-decrement
    end
  end

endmodule

// File: src/sm_isr.sv
`timescale 1ns/1ps
/* Input shift register. IN shifts data in from either end, MOV loads it
   and PUSH clears it */
module sm_isr (
  input  logic                      clk,
  input  logic                      reset,
  input  sm_pkg::sm_dp_cmd_t        cmd,
  input  logic                      shift_right,
  output logic [sm_pkg::WORD_W-1:0] isr_val
);

  localparam int W = sm_pkg::WORD_W;

  logic [5:0]     n;
  logic [2*W-1:0] cat_r;
  logic [2*W-1:0] cat_l;

  assign n = (cmd.shift_n == '0) ? 6'(W) : {1'b0, cmd.shift_n};

  // New bits enter at the top when shifting right
  assign cat_r = {cmd.new_val, isr_val} >> n;
  // Left shift takes the low n bits of new_val in at the bottom
  assign cat_l = {isr_val, cmd.new_val << (6'(W) - n)} << n;

  always_ff @(posedge clk) begin
    if (reset) begin
      isr_val <= '0;
    end else if (cmd.clr_isr) begin
      isr_val <= '0;
    end else if (cmd.set_isr) begin
      isr_val <= cmd.new_val;
    end else if (cmd.shift_isr) begin
      isr_val <= shift_right ? cat_r[W-1:0] : cat_l[2*W-1:W];
    end
  end

endmodule

// File: src/sm_osr.sv
`timescale 1ns/1ps
/* Output shift register. PULL and MOV load it, OUT takes a field from one
   end, shown right-aligned on out_bits */
module sm_osr (
  input  logic                      clk,
  input  logic                      reset,
  input  sm_pkg::sm_dp_cmd_t        cmd,
  input  logic                      shift_right,
  output logic [sm_pkg::WORD_W-1:0] osr_val,
  output logic [sm_pkg::WORD_W-1:0] out_bits
);

  localparam int W = sm_pkg::WORD_W;

  logic [5:0]   n;
  logic [W-1:0] low_mask;

  assign n        = (cmd.shift_n == '0) ? 6'(W) : {1'b0, cmd.shift_n};
  assign low_mask = {W{1'b1}} >> (6'(W) - n);

  // Low bits leave on a right shift, high bits on a left shift
  assign out_bits = shift_right ? (osr_val & low_mask) : (osr_val >> (6'(W) - n));

  always_ff @(posedge clk) begin
    if (reset) begin
      osr_val <= '0;
    end else if (cmd.set_osr) begin
      osr_val <= cmd.new_val;
    end else if (cmd.shift_osr) begin
      osr_val <= shift_right ? (osr_val >> n) : (osr_val << n);  // Zero fill
    end
  end

endmodule

// File: src/sm_pin_port.sv
`timescale 1ns/1ps
/* Pin output and direction registers written through base/count windows,
   and the input pins rotated so in_base lands at bit 0 */
module sm_pin_port #(
  parameter int NUM_PINS = 32
) (
  input  logic                      clk,
  input  logic                      reset,
  input  sm_pkg::sm_config_t        cfg,
  input  sm_pkg::sm_dp_cmd_t        cmd,
  input  logic [NUM_PINS-1:0]       in_pins,
  output logic [NUM_PINS-1:0]       out_pins,
  output logic [NUM_PINS-1:0]       pin_dirs,
  output logic [sm_pkg::WORD_W-1:0] in_rot
);

  // Writes count bits of val starting at pin base, wrapping past the top
  function automatic logic [NUM_PINS-1:0] merge_field(
    input logic [NUM_PINS-1:0]       cur,
    input logic [4:0]                base,
    input logic [5:0]                count,
    input logic [sm_pkg::WORD_W-1:0] val
  );
    logic [NUM_PINS-1:0] r;
    r = cur;
    for (int k = 0; k < sm_pkg::WORD_W; k++) begin
      if (k < count) begin
        r[(base + k) % NUM_PINS] = val[k];
      end
    end
    return r;
  endfunction

  always_comb begin
    in_rot = '0;
    for (int k = 0; k < sm_pkg::WORD_W; k++) begin
      if (k < NUM_PINS) begin
        in_rot[k] = in_pins[(k + cfg.in_base) % NUM_PINS];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_pins <= '0;
      pin_dirs <= '0;
    end else begin
      if (cmd.wr_set_pins) begin
        out_pins <= merge_field(out_pins, cfg.set_base, {3'b000, cfg.set_count}, cmd.new_val);
      end else if (cmd.wr_out_pins) begin
        out_pins <= merge_field(out_pins, cfg.out_base, cfg.out_count, cmd.new_val);
      end
      if (cmd.wr_set_dirs) begin
        pin_dirs <= merge_field(pin_dirs, cfg.set_base, {3'b000, cfg.set_count}, cmd.new_val);
      end
    end
  end

endmodule

// File: src/sm_control.sv
`timescale 1ns/1ps
/* Instruction decode and execute. Turns the current instruction into a
   data path command and FIFO strobes, and steps the program counter */
module sm_control (
  input  logic                      clk,
  input  logic                      reset,
  input  sm_pkg::sm_config_t        cfg,
  input  sm_pkg::sm_instr_u         instr,
  input  logic                      tick,
  input  logic                      delaying,
  input  logic [sm_pkg::WORD_W-1:0] x,
  input  logic [sm_pkg::WORD_W-1:0] y,
  input  logic [sm_pkg::WORD_W-1:0] isr_val,
  input  logic [sm_pkg::WORD_W-1:0] osr_val,
  input  logic [sm_pkg::WORD_W-1:0] out_bits,
  input  logic [sm_pkg::WORD_W-1:0] in_rot,
  input  logic [sm_pkg::WORD_W-1:0] tx_data,
  input  logic                      tx_empty,
  input  logic                      rx_full,
  output sm_pkg::sm_dp_cmd_t        cmd,
  output logic                      load,
  output logic [4:0]                delay_val,
  output logic [sm_pkg::PC_W-1:0]   pc,
  output logic                      pull,
  output logic                      push,
  output logic [sm_pkg::WORD_W-1:0] rx_data,
  output logic                      stalled
);

  typedef enum logic {RUN, STALL} state_e;

  state_e                    state;
  sm_pkg::sm_op_e            op;
  logic [2:0]                arg_a;
  logic [4:0]                arg_b;
  logic [2:0]                src_sel;
  logic [sm_pkg::WORD_W-1:0] src_val;
  logic [sm_pkg::WORD_W-1:0] mov_val;
  logic                      exec_en;
  logic                      stall_now;
  logic                      jump;
  logic [sm_pkg::PC_W-1:0]   jump_addr;
  logic [sm_pkg::PC_W-1:0]   next_pc;

  function automatic logic [sm_pkg::WORD_W-1:0] apply_op(
    input logic [sm_pkg::WORD_W-1:0] v,
    input logic [1:0]                mop
  );
    logic [sm_pkg::WORD_W-1:0] r;
    r = v;
    case (mop)
      2'd1: r = ~v;
      2'd2: begin
        for (int i = 0; i < sm_pkg::WORD_W; i++) begin
          r[i] = v[sm_pkg::WORD_W-1-i];
        end
      end
      default: r = v;  // Code 3 is reserved
    endcase
    return r;
  endfunction

  assign op        = instr.fields.op;
  assign arg_a     = instr.fields.arg_a;
  assign arg_b     = instr.fields.arg_b;
  assign delay_val = instr.fields.delay;
  assign exec_en   = tick && !delaying;
  assign src_sel   = (op == sm_pkg::MOV) ? instr.mov.src : arg_a;  // IN and MOV share the mux
  assign mov_val   = apply_op(src_val, instr.mov.mov_op);
  assign load      = exec_en && !stall_now;  // Delay starts once the instruction completes
  assign rx_data   = isr_val;
  assign stalled   = (state == STALL);

  always_comb begin
    case (src_sel)
      3'd0:    src_val = in_rot;
      3'd1:    src_val = x;
      3'd2:    src_val = y;
      3'd6:    src_val = isr_val;
      3'd7:    src_val = osr_val;
      default: src_val = '0;  // NULL
    endcase
  end

  always_comb begin
    cmd       = '0;
    pull      = 1'b0;
    push      = 1'b0;
    stall_now = 1'b0;
    jump      = 1'b0;
    jump_addr = arg_b;
    if (exec_en) begin
      case (op)
        sm_pkg::JMP: begin
          case (arg_a)
            3'd0: jump = 1'b1;
            3'd1: jump = (x == '0);
            3'd2: begin
              jump      = (x != '0);
              cmd.dec_x = jump;  // Post-decrement only when taken
            end
            3'd3: jump = (y == '0);
            3'd4: begin
              jump      = (y != '0);
              cmd.dec_y = jump;
            end
            3'd5: jump = (x != y);
            default: jump = 1'b0;
          endcase
        end
        sm_pkg::IN: begin
          if (!arg_a[2]) begin  // Pins, X, Y or NULL
            cmd.shift_isr = 1'b1;
            cmd.shift_n   = arg_b;
            cmd.new_val   = src_val;
          end
        end
        sm_pkg::OUT: begin
          if (arg_a <= 3'd3 || arg_a == 3'd5) begin
            cmd.shift_osr = 1'b1;
            cmd.shift_n   = arg_b;
            cmd.new_val   = out_bits;
            case (arg_a)
              3'd0: cmd.wr_out_pins = 1'b1;
              3'd1: cmd.set_x = 1'b1;
              3'd2: cmd.set_y = 1'b1;
              3'd5: begin
                jump      = 1'b1;
                jump_addr = out_bits[sm_pkg::PC_W-1:0];
              end
              default: cmd.shift_osr = 1'b1;  // NULL just discards
            endcase
          end
        end
        sm_pkg::PUSH_PULL: begin
          if (!arg_a[2]) begin  // PUSH
            if (!rx_full) begin
              push        = 1'b1;
              cmd.clr_isr = 1'b1;
            end else begin
              stall_now = arg_a[0];  // Block bit
            end
          end else if (!tx_empty) begin  // PULL with data waiting
            pull        = 1'b1;
            cmd.set_osr = 1'b1;
            cmd.new_val = tx_data;
          end else if (arg_a[0]) begin
            stall_now = 1'b1;
          end else begin
            cmd.set_osr = 1'b1;  // Empty non-blocking pull takes X
            cmd.new_val = x;
          end
        end
        sm_pkg::MOV: begin
          if (instr.mov.src[2:1] != 2'b10) begin  // Sources 4 and 5 unsupported
            cmd.new_val = mov_val;
            case (instr.mov.dest)
              3'd0: cmd.wr_out_pins = 1'b1;
              3'd1: cmd.set_x = 1'b1;
              3'd2: cmd.set_y = 1'b1;
              3'd6: cmd.set_isr = 1'b1;
              3'd7: cmd.set_osr = 1'b1;
              default: cmd.set_x = 1'b0;  // Pindirs, EXEC and PC ignored
            endcase
          end
        end
        sm_pkg::SET: begin
          cmd.new_val = {{(sm_pkg::WORD_W-5){1'b0}}, arg_b};
          case (arg_a)
            3'd0: cmd.wr_set_pins = 1'b1;
            3'd1: cmd.set_x = 1'b1;
            3'd2: cmd.set_y = 1'b1;
            3'd4: cmd.wr_set_dirs = 1'b1;
            default: cmd.set_x = 1'b0;
          endcase
        end
        default: jump = 1'b0;  // WAIT and IRQ fall through as no-ops
      endcase
    end
  end

  assign next_pc = jump ? jump_addr :
                   (pc == cfg.wrap_end) ? cfg.wrap_target : pc + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= '0;
      state <= RUN;
    end else if (exec_en) begin
      state <= stall_now ? STALL : RUN;
      if (!stall_now) begin
        pc <= next_pc;  // A stall retries the same word
      end
    end
  end

endmodule

// File: src/sm_top.sv
`timescale 1ns/1ps
/* State machine top level. Connects the controller, the tick timer and the
   data registers; the program store and FIFOs sit outside */
module sm_top #(
  parameter int NUM_PINS = 32,
  parameter int DIV_W    = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  sm_pkg::sm_config_t        cfg,
  input  logic [DIV_W-1:0]          div_int,
  input  sm_pkg::sm_instr_u         instr,
  input  logic [NUM_PINS-1:0]       in_pins,
  input  logic [sm_pkg::WORD_W-1:0] tx_data,
  input  logic                      tx_empty,
  input  logic                      rx_full,
  output logic [sm_pkg::PC_W-1:0]   pc,
  output logic [NUM_PINS-1:0]       out_pins,
  output logic [NUM_PINS-1:0]       pin_dirs,
  output logic                      pull,
  output logic                      push,
  output logic [sm_pkg::WORD_W-1:0] rx_data,
  output logic                      stalled
);

  sm_pkg::sm_dp_cmd_t        cmd;
  logic                      tick;
  logic                      delaying;
  logic                      load;
  logic [4:0]                delay_val;
  logic [sm_pkg::WORD_W-1:0] x;
  logic [sm_pkg::WORD_W-1:0] y;
  logic [sm_pkg::WORD_W-1:0] isr_val;
  logic [sm_pkg::WORD_W-1:0] osr_val;
  logic [sm_pkg::WORD_W-1:0] out_bits;
  logic [sm_pkg::WORD_W-1:0] in_rot;

  sm_control u_control (
    .clk(clk), .reset(reset), .cfg(cfg), .instr(instr),
    .tick(tick), .delaying(delaying),
    .x(x), .y(y), .isr_val(isr_val), .osr_val(osr_val),
    .out_bits(out_bits), .in_rot(in_rot),
    .tx_data(tx_data), .tx_empty(tx_empty), .rx_full(rx_full),
    .cmd(cmd), .load(load), .delay_val(delay_val), .pc(pc),
    .pull(pull), .push(push), .rx_data(rx_data), .stalled(stalled)
  );

  sm_tick_timer #(.DIV_W(DIV_W)) u_timer (
    .clk(clk), .reset(reset), .div_int(div_int), .load(load),
    .delay_val(delay_val), .tick(tick), .delaying(delaying)
  );

  sm_scratch u_x (
    .clk(clk), .reset(reset), .set(cmd.set_x), .dec(cmd.dec_x),
    .din(cmd.new_val), .q(x)
  );

  sm_scratch u_y (
    .clk(clk), .reset(reset), .set(cmd.set_y), .dec(cmd.dec_y),
    .din(cmd.new_val), .q(y)
  );

  sm_isr u_isr (
    .clk(clk), .reset(reset), .cmd(cmd), .shift_right(cfg.in_shift_right),
    .isr_val(isr_val)
  );

  sm_osr u_osr (
    .clk(clk), .reset(reset), .cmd(cmd), .shift_right(cfg.out_shift_right),
    .osr_val(osr_val), .out_bits(out_bits)
  );

  sm_pin_port #(.NUM_PINS(NUM_PINS)) u_pins (
    .clk(clk), .reset(reset), .cfg(cfg), .cmd(cmd), .in_pins(in_pins),
    .out_pins(out_pins), .pin_dirs(pin_dirs), .in_rot(in_rot)
  );

endmodule

// File: tests/tb_sm.sv
`timescale 1ns/1ps
/* Directed testbench for sm_top. A program array answers pc, two queues
   model the TX and RX FIFOs, and each test task runs one small program */
module tb_sm;

  localparam int NUM_PINS = 32;
  localparam int DIV_W    = 16;
  localparam int WAIT_MAX = 400;  // Cycles per wait loop

  logic                      clk;
  logic                      reset;
  sm_pkg::sm_config_t        cfg;
  logic [DIV_W-1:0]          div_int;
  sm_pkg::sm_instr_u         instr;
  logic [NUM_PINS-1:0]       in_pins;
  logic [sm_pkg::WORD_W-1:0] tx_data;
  logic                      tx_empty;
  logic                      rx_full;
  logic [sm_pkg::PC_W-1:0]   pc;
  logic [NUM_PINS-1:0]       out_pins;
  logic [NUM_PINS-1:0]       pin_dirs;
  logic                      pull;
  logic                      push;
  logic [sm_pkg::WORD_W-1:0] rx_data;
  logic                      stalled;

  sm_pkg::sm_instr_u prog [32];
  logic [31:0]       tx_q [$];
  logic [31:0]       rx_q [$];
  int                push_cyc [$];  // Cycle number of each push
  int                cyc;
  logic [15:0]       lfsr;

  sm_top #(.NUM_PINS(NUM_PINS), .DIV_W(DIV_W)) u_dut (
    .clk(clk), .reset(reset), .cfg(cfg), .div_int(div_int), .instr(instr),
    .in_pins(in_pins), .tx_data(tx_data), .tx_empty(tx_empty), .rx_full(rx_full),
    .pc(pc), .out_pins(out_pins), .pin_dirs(pin_dirs), .pull(pull), .push(push),
    .rx_data(rx_data), .stalled(stalled)
  );

  always #4 clk = ~clk;

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // FIFO strobes are taken mid-cycle; a pull pops now, tx_data moves later
  always @(negedge clk) begin
    cyc++;
    if (!reset) begin
      if (push === 1'b1) begin
        if (rx_full) begin
          stop_with_error("push was raised while rx_full was high");
        end
        rx_q.push_back(rx_data);
        push_cyc.push_back(cyc);
      end
      if (pull === 1'b1) begin
        if (tx_empty) begin
          stop_with_error("pull was raised while tx_empty was high");
        end
        void'(tx_q.pop_front());
      end
    end
  end

  // Program store and TX FIFO head, driven just after the rising edge
  always @(posedge clk) begin
    #1;
    tx_empty = (tx_q.size() == 0);
    tx_data  = tx_empty ? 32'd0 : tx_q[0];
    instr    = prog[pc];
  end

  function automatic sm_pkg::sm_instr_u make_instr(input sm_pkg::sm_op_e op,
                                                   input logic [4:0] delay,
                                                   input logic [2:0] a, input logic [4:0] b);
    sm_pkg::sm_instr_u i;
    i.fields.op    = op;
    i.fields.delay = delay;
    i.fields.arg_a = a;
    i.fields.arg_b = b;
    return i;
  endfunction

  function automatic sm_pkg::sm_instr_u make_mov(input logic [2:0] dest, input logic [1:0] mop,
                                                 input logic [2:0] src);
    sm_pkg::sm_instr_u i;
    i.mov.op     = sm_pkg::MOV;
    i.mov.delay  = 5'd0;
    i.mov.dest   = dest;
    i.mov.mov_op = mop;
    i.mov.src    = src;
    return i;
  endfunction

  // x^16 + x^14 + x^13 + x^11
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic logic [31:0] reverse_bits(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[i] = v[31-i];
    end
    return r;
  endfunction

  task automatic check_word(input string name, input logic [sm_pkg::WORD_W-1:0] got,
                            input logic [sm_pkg::WORD_W-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s = 0x%h, expected 0x%h",
                                $time, name, got, exp));
    end
  endtask

  task automatic check_pc(input logic [sm_pkg::PC_W-1:0] got, input logic [sm_pkg::PC_W-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: pc = %0d, expected %0d", $time, got, exp));
    end
  endtask

  task automatic check_pins(input string name, input logic [NUM_PINS-1:0] got,
                            input logic [NUM_PINS-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s = 0x%h, expected 0x%h",
                                $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic drive_point();
    @(posedge clk);
    #1;
  endtask

  task automatic sample_point();
    @(negedge clk);
    #1;
  endtask

  task automatic wait_pc(input logic [sm_pkg::PC_W-1:0] target);
    int t;
    t = 0;
    sample_point();
    while (pc !== target) begin
      t++;
      if (t > WAIT_MAX) begin
        stop_with_error($sformatf("pc did not reach %0d in time", target));
      end
      sample_point();
    end
  endtask

  task automatic wait_rx(input int n);
    int t;
    t = 0;
    sample_point();
    while (rx_q.size() < n) begin
      t++;
      if (t > WAIT_MAX) begin
        stop_with_error($sformatf("only %0d of %0d RX words arrived", rx_q.size(), n));
      end
      sample_point();
    end
  endtask

  task automatic wait_stalled();
    int t;
    t = 0;
    sample_point();
    while (stalled !== 1'b1) begin
      t++;
      if (t > WAIT_MAX) begin
        stop_with_error("the state machine never stalled");
      end
      sample_point();
    end
  endtask

  // Puts the DUT in reset and clears the program to jumps onto themselves
  task automatic begin_test();
    drive_point();
    reset   = 1'b1;
    rx_full = 1'b0;
    div_int = 16'd1;
    cfg     = '0;
    cfg.wrap_end  = 5'd31;
    cfg.set_count = 3'd5;
    cfg.out_count = 6'd32;
    for (int a = 0; a < 32; a++) begin
      prog[a] = make_instr(sm_pkg::JMP, 5'd0, 3'd0, 5'(a));
    end
    tx_q.delete();
    rx_q.delete();
    push_cyc.delete();
  endtask

  task automatic release_reset();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic test_set_mov();
    begin_test();
    cfg.set_base  = 5'd4;
    cfg.set_count = 3'd3;
    prog[0] = make_instr(sm_pkg::SET, 5'd0, 3'd1, 5'd5);
    prog[1] = make_mov(3'd2, 2'd1, 3'd1);  // Y = ~X
    prog[2] = make_mov(3'd6, 2'd2, 3'd2);  // ISR = reversed Y
    prog[3] = make_instr(sm_pkg::PUSH_PULL, 5'd0, 3'b001, 5'd0);
    prog[4] = make_instr(sm_pkg::SET, 5'd0, 3'd0, 5'b11101);  // Only 3'b101 fits
    prog[5] = make_instr(sm_pkg::SET, 5'd0, 3'd4, 5'b01110);  // Dirs get 3'b110
    release_reset();
    wait_pc(5'd6);
    check_word("rx word count", 32'(rx_q.size()), 32'd1);
    check_word("rx_data", rx_q[0], reverse_bits(~32'd5));
    check_pins("out_pins", out_pins, 32'b101 << 4);
    check_pins("pin_dirs", pin_dirs, 32'b110 << 4);
  endtask

  task automatic test_jmp_loop();
    begin_test();
    prog[0] = make_instr(sm_pkg::SET, 5'd0, 3'd1, 5'd3);
    prog[1] = make_mov(3'd6, 2'd0, 3'd1);
    prog[2] = make_instr(sm_pkg::PUSH_PULL, 5'd0, 3'b001, 5'd0);
    prog[3] = make_instr(sm_pkg::JMP, 5'd0, 3'd2, 5'd1);  // X-- loop
    prog[4] = make_instr(sm_pkg::SET, 5'd0, 3'd2, 5'd7);
    release_reset();
    wait_pc(5'd5);
    check_word("rx word count", 32'(rx_q.size()), 32'd4);
    for (int i = 0; i < 4; i++) begin
      check_word("rx_data", rx_q[i], 32'(3 - i));
    end
  endtask

  task automatic test_shift_swap();
    logic [31:0] expect_w [4];
    logic [31:0] osr;
    logic [31:0] isr;
    begin_test();
    cfg.out_shift_right = 1'b1;
    for (int w = 0; w < 4; w++) begin
      osr = rand_word();
      tx_q.push_back(osr);
      isr = '0;
      for (int k = 0; k < 4; k++) begin
        isr = {isr[23:0], osr[7:0]};  // Low byte out first, entering ISR at the bottom
        osr = osr >> 8;
      end
      expect_w[w] = isr;
    end
    prog[0] = make_instr(sm_pkg::PUSH_PULL, 5'd0, 3'b101, 5'd0);
    for (int k = 0; k < 4; k++) begin
      prog[1 + 2 * k] = make_instr(sm_pkg::OUT, 5'd0, 3'd1, 5'd8);
      prog[2 + 2 * k] = make_instr(sm_pkg::IN, 5'd0, 3'd1, 5'd8);
    end
    prog[9]  = make_instr(sm_pkg::PUSH_PULL, 5'd0, 3'b001, 5'd0);
    prog[10] = make_instr(sm_pkg::JMP, 5'd0, 3'd0, 5'd0);
    release_reset();
    wait_rx(4);
    for (int w = 0; w < 4; w++) begin
      check_word("rx_data", rx_q[w], expect_w[w]);
    end
    wait_stalled();  // Fifth PULL finds the FIFO empty
    check_pc(pc, 5'd0);
  endtask

  task automatic test_back_pressure();
    begin_test();
    rx_full = 1'b1;
    prog[0] = make_instr(sm_pkg::SET, 5'd0, 3'd1, 5'd9);
    prog[1] = make_mov(3'd6, 2'd0, 3'd1);
    prog[2] = make_instr(sm_pkg::PUSH_PULL, 5'd0, 3'b001, 5'd0);
    prog[3] = make_instr(sm_pkg::SET, 5'd0, 3'd1, 5'd17);
    prog[4] = make_instr(sm_pkg::PUSH_PULL, 5'd0, 3'b100, 5'd0);  // Empty, so OSR = X
    prog[5] = make_mov(3'd6, 2'd0, 3'd7);
    prog[6] = make_instr(sm_pkg::PUSH_PULL, 5'd0, 3'b001, 5'd0);
    release_reset();
    wait_stalled();
    repeat (6) begin
      sample_point();
      check_pc(pc, 5'd2);
      check_flag("push", push, 1'b0);
      check_flag("stalled", stalled, 1'b1);
    end
    check_word("rx word count", 32'(rx_q.size()), 32'd0);
    drive_point();
    rx_full = 1'b0;
    wait_pc(5'd7);
    repeat (4) sample_point();
    check_word("rx word count", 32'(rx_q.size()), 32'd2);
    check_word("rx_data", rx_q[0], 32'd9);
    check_word("rx_data", rx_q[1], 32'd17);
    check_flag("stalled", stalled, 1'b0);
  endtask

  task automatic test_divider_wrap();
    begin_test();
    div_int         = 16'd3;
    cfg.wrap_target = 5'd0;
    cfg.wrap_end    = 5'd1;
    prog[0] = make_instr(sm_pkg::PUSH_PULL, 5'd2, 3'b001, 5'd0);
    prog[1] = make_mov(3'd6, 2'd0, 3'd2);
    release_reset();
    wait_rx(4);
    for (int i = 1; i < 4; i++) begin
      check_word("push spacing", 32'(push_cyc[i] - push_cyc[i-1]), 32'(3 * ((1 + 2) + (1 + 0))));
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    cfg      = '0;
    div_int  = 16'd1;
    instr    = '0;
    in_pins  = '0;
    tx_data  = '0;
    tx_empty = 1'b1;
    rx_full  = 1'b0;
    cyc      = 0;
    lfsr     = 16'd63468;
    test_set_mov();
    test_jmp_loop();
    test_shift_swap();
    test_back_pressure();
    test_divider_wrap();
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: sources.f
src/sm_pkg.sv
src/sm_tick_timer.sv
src/sm_scratch.sv
src/sm_isr.sv
src/sm_osr.sv
src/sm_pin_port.sv
src/sm_control.sv
src/sm_top.sv
tests/tb_sm.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the state machine testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sm -f sources.f \
  -Mdir obj_dir -o tb_sm_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_sm_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation passed" <<< "$output"; then
  exit 0
fi
exit 1
